//--- rtl/block_stats.sv
// ====================
// input side, buffers one 64-pixel block and computes its stats
// mean = sum >> 6, variance = (sumsq >> 6) - mean^2
// no back-pressure: a new block must wait for the previous block_done
// rd_data is registered, valid one cycle after rd_addr
// ====================
`timescale 1ns/1ps

module block_stats (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                pix_valid,
	input  logic [wiener_pkg::PIX_W-1:0]        pix_data,
	input  logic [wiener_pkg::LOG2_SAMPLES-1:0] rd_addr,
	output logic [wiener_pkg::PIX_W-1:0]        rd_data,
	output logic                                stats_ready,
	output wiener_pkg::block_stats_t            stats
);
	import wiener_pkg::*;

	logic [PIX_W-1:0]        pix_mem [BLOCK_SAMPLES]; // block buffer
	logic [LOG2_SAMPLES-1:0] wr_ptr;                  // also counts pixels in block
	logic [13:0]             sum_acc;                 // 64 * 255 fits in 14 bits
	logic [21:0]             sumsq_acc;               // 64 * 255^2 fits in 22 bits
	logic [13:0]             sum_next;
	logic [21:0]             sumsq_next;
	logic [2*PIX_W-1:0]      pix_sq;
	logic [PIX_W-1:0]        mean_next;
	logic [VAR_W-1:0]        mean_sq;
	logic [VAR_W-1:0]        msq_next;                // mean of squares
	logic                    block_end;

	always_comb begin
		pix_sq     = pix_data * pix_data;
		sum_next   = sum_acc + 14'(pix_data);
		sumsq_next = sumsq_acc + 22'(pix_sq);
		mean_next  = sum_next[LOG2_SAMPLES +: PIX_W];     // sum >> 6
		msq_next   = sumsq_next[LOG2_SAMPLES +: VAR_W];   // sumsq >> 6
		mean_sq    = mean_next * mean_next;
		block_end  = pix_valid && (wr_ptr == LOG2_SAMPLES'(BLOCK_SAMPLES - 1));
	end

	// buffer write and synchronous read port
	always_ff @(posedge clk) begin
		if (pix_valid)
			pix_mem[wr_ptr] <= pix_data;
		rd_data <= pix_mem[rd_addr]; // read every cycle, caller tracks validity
	end

	// accumulators and handshake pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			sum_acc     <= '0;
			sumsq_acc   <= '0;
			stats_ready <= 1'b0;
		end else begin
			stats_ready <= block_end; // one cycle after the 64th pixel
			if (pix_valid) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps to 0 after the last pixel
				if (block_end) begin
					sum_acc   <= '0; // fresh start for the next block
					sumsq_acc <= '0;
				end else begin
					sum_acc   <= sum_next;
					sumsq_acc <= sumsq_next;
				end
			end
		end
	end

	// stats held until the next block completes
	// floor(E[x^2]) >= floor(E[x])^2, so the difference never goes negative
	always_ff @(posedge clk) begin
		if (block_end) begin
			stats.mean     <= mean_next;
			stats.variance <= msq_next - mean_sq;
		end
	end

endmodule

//--- rtl/gain_divider.sv
// ====================
// restoring divider, 32-bit dividend by 16-bit divisor
// first quotient bit is resolved on the div_start edge
// div_done pulses exactly 32 cycles after div_start
// only the low 17 quotient bits are kept, zero divisor gives zero
// ====================
`timescale 1ns/1ps

module gain_divider (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         div_start,
	input  logic [31:0]                  dividend,
	input  logic [wiener_pkg::VAR_W-1:0] divisor,
	output logic                         div_done,
	output wiener_pkg::gain_t            gain
);
	import wiener_pkg::*;

	logic [31:0]      quo_q;     // dividend shifts out, quotient shifts in
	logic [VAR_W-1:0] rem_q;     // partial remainder, always below divisor
	logic [VAR_W-1:0] div_q;     // divisor latched on start
	logic             zero_q;    // divide by zero seen on start
	logic             busy;
	logic [4:0]       iter_cnt;  // quotient bits already resolved
	logic [31:0]      quo_src;
	logic [VAR_W-1:0] rem_src;
	logic [VAR_W-1:0] dsr_src;
	logic [VAR_W:0]   trial;     // remainder shifted with next dividend bit
	logic             q_bit;
	logic [31:0]      quo_next;
	logic [VAR_W-1:0] rem_next;
	logic             last_iter;

	always_comb begin
		quo_src   = div_start ? dividend : quo_q;
		rem_src   = div_start ? '0 : rem_q;
		dsr_src   = div_start ? divisor : div_q;
		trial     = {rem_src, quo_src[31]};
		q_bit     = trial >= {1'b0, dsr_src};
		rem_next  = q_bit ? VAR_W'(trial - {1'b0, dsr_src}) : trial[VAR_W-1:0];
		quo_next  = {quo_src[30:0], q_bit};
		last_iter = busy && (iter_cnt == 5'd31);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			iter_cnt <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= last_iter;
			if (div_start) begin
				busy     <= 1'b1;
				iter_cnt <= 5'd1; // start edge already did bit 31
			end else if (busy) begin
				iter_cnt <= iter_cnt + 1'b1;
				if (last_iter)
					busy <= 1'b0;
			end
		end
	end

	// datapath, one quotient bit per active edge
	always_ff @(posedge clk) begin
		if (div_start || busy) begin
			quo_q <= quo_next;
			rem_q <= rem_next;
		end
		if (div_start) begin
			div_q  <= divisor;
			zero_q <= (divisor == '0);
		end
		if (last_iter)
			gain <= zero_q ? '0 : quo_next[FRAC_W:0]; // held until next result
	end

endmodule

//--- rtl/pixel_out_stage.sv
// ====================
// output side, one register stage on the filtered stream
// block_done marks the last pixel, frame_done rides on it
// every blocks_per_frame blocks, a value of 0 never matches
// ====================
`timescale 1ns/1ps

module pixel_out_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  calc_valid,
	input  wiener_pkg::filt_pix_t calc_pix,
	input  logic [31:0]           blocks_per_frame,
	output logic                  out_valid,
	output wiener_pkg::filt_pix_t out_pix,
	output logic                  block_done,
	output logic                  frame_done
);
	import wiener_pkg::*;

	filt_pix_t   pix_q;     // registered pixel and last flag
	logic [31:0] blk_cnt;   // completed blocks in the current frame
	logic        blk_end;
	logic        frame_end;

	assign blk_end   = calc_valid && calc_pix.last;
	assign frame_end = blk_end && (blk_cnt == blocks_per_frame - 32'd1);
	assign out_pix   = pix_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid  <= 1'b0;
			block_done <= 1'b0;
			frame_done <= 1'b0;
			blk_cnt    <= '0;
		end else begin
			out_valid  <= calc_valid;
			block_done <= blk_end;
			frame_done <= frame_end;
			if (frame_end)
				blk_cnt <= '0;                   // wrap for the next frame
			else if (blk_end)
				blk_cnt <= blk_cnt + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		pix_q <= calc_pix; // qualified by out_valid downstream
	end

endmodule

//--- rtl/wiener_calc.sv
// ====================
// processing part, gain = clamp0(var - noise) / var in 16.16
// out = mean +/- ((gain * |pix - mean|) >> 16), truncated
// result lies between mean and pixel, so no 0..255 clip is needed
// reads start on div_done, calc_valid follows each read by 2 cycles
// stats must stay stable while the block streams out
// ====================
`timescale 1ns/1ps

module wiener_calc (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                stats_ready,
	input  wiener_pkg::block_stats_t            stats,
	input  logic [wiener_pkg::VAR_W-1:0]        noise_variance,
	output logic [wiener_pkg::LOG2_SAMPLES-1:0] rd_addr,
	input  logic [wiener_pkg::PIX_W-1:0]        rd_data,
	output logic                                calc_valid,
	output wiener_pkg::filt_pix_t               calc_pix
);
	import wiener_pkg::*;

	calc_state_t             state;
	logic                    div_start;
	logic                    div_done;
	logic [VAR_W-1:0]        excess;    // variance above the noise floor
	logic [31:0]             dividend;
	gain_t                   gain;
	logic [LOG2_SAMPLES-1:0] rd_cnt;
	logic                    rd_en;     // a buffer read is issued this cycle
	logic                    rd_valid;  // rd_data carries a block pixel
	logic                    rd_last;
	logic                    diff_neg;  // pixel below mean
	logic [PIX_W-1:0]        abs_diff;
	logic [PIX_W+FRAC_W:0]   product;
	logic [PIX_W-1:0]        scaled;

	// clamp at zero, also covers a zero block variance
	assign excess   = (stats.variance > noise_variance) ? stats.variance - noise_variance : '0;
	assign dividend = {excess, {FRAC_W{1'b0}}}; // excess << 16

	gain_divider u_gain_divider (
		.clk       (clk),
		.rst_n     (rst_n),
		.div_start (div_start),
		.dividend  (dividend),
		.divisor   (stats.variance),
		.div_done  (div_done),
		.gain      (gain)
	);

	// first read overlaps the div_done cycle
	assign rd_en   = (state == CALC_DIVIDE && div_done) || (state == CALC_STREAM);
	assign rd_addr = rd_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= CALC_IDLE;
			div_start  <= 1'b0;
			rd_cnt     <= '0;
			rd_valid   <= 1'b0;
			rd_last    <= 1'b0;
			calc_valid <= 1'b0;
		end else begin
			div_start  <= 1'b0;
			rd_valid   <= rd_en;                  // aligns with registered rd_data
			rd_last    <= rd_en && (rd_cnt == LOG2_SAMPLES'(BLOCK_SAMPLES - 1));
			calc_valid <= rd_valid;
			if (rd_en)
				rd_cnt <= rd_cnt + 1'b1;           // wraps to 0 after 64 reads
			case (state)
				CALC_IDLE: begin
					if (stats_ready) begin
						div_start <= 1'b1;
						state     <= CALC_DIVIDE;
					end
				end
				CALC_DIVIDE: begin
					if (div_done)
						state <= CALC_STREAM;
				end
				CALC_STREAM: begin
					if (rd_cnt == LOG2_SAMPLES'(BLOCK_SAMPLES - 1))
						state <= CALC_IDLE;
				end
				default: state <= CALC_IDLE;
			endcase
		end
	end

	// arithmetic stage on the registered buffer output
	always_comb begin
		diff_neg = rd_data < stats.mean;
		abs_diff = diff_neg ? stats.mean - rd_data : rd_data - stats.mean;
		product  = gain * abs_diff;                       // gain <= 1.0, never exceeds abs_diff
		scaled   = product[FRAC_W +: PIX_W];              // >> 16, truncate
	end

	always_ff @(posedge clk) begin
		calc_pix.data <= diff_neg ? stats.mean - scaled : stats.mean + scaled;
		calc_pix.last <= rd_last;
	end

endmodule

//--- rtl/wiener_denoise_top.sv
// ====================
// block Wiener denoiser for one 8-bit channel
// no back-pressure, send the next block only after block_done
// noise_variance held stable during a block
// last pixel in to first out_valid is 37 cycles
// ====================
`timescale 1ns/1ps

module wiener_denoise_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         pix_valid,
	input  logic [wiener_pkg::PIX_W-1:0] pix_data,
	input  logic [wiener_pkg::VAR_W-1:0] noise_variance,
	input  logic [31:0]                  blocks_per_frame,
	output logic                         out_valid,
	output wiener_pkg::filt_pix_t        out_pix,
	output logic                         block_done,
	output logic                         frame_done
);
	import wiener_pkg::*;

	logic                    stats_ready;
	block_stats_t            stats;
	logic [LOG2_SAMPLES-1:0] rd_addr;
	logic [PIX_W-1:0]        rd_data;
	logic                    calc_valid;
	filt_pix_t               calc_pix;

	block_stats u_block_stats (
		.clk         (clk),
		.rst_n       (rst_n),
		.pix_valid   (pix_valid),
		.pix_data    (pix_data),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.stats_ready (stats_ready),
		.stats       (stats)
	);

	wiener_calc u_wiener_calc (
		.clk            (clk),
		.rst_n          (rst_n),
		.stats_ready    (stats_ready),
		.stats          (stats),
		.noise_variance (noise_variance),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.calc_valid     (calc_valid),
		.calc_pix       (calc_pix)
	);

	pixel_out_stage u_pixel_out_stage (
		.clk              (clk),
		.rst_n            (rst_n),
		.calc_valid       (calc_valid),
		.calc_pix         (calc_pix),
		.blocks_per_frame (blocks_per_frame),
		.out_valid        (out_valid),
		.out_pix          (out_pix),
		.block_done       (block_done),
		.frame_done       (frame_done)
	);

endmodule

//--- rtl/wiener_pkg.sv
// ====================
// shared widths, payload structs and the calc FSM encoding
// VAR_W + FRAC_W must equal 32, the divider dividend width
// gain is unsigned 16.16 with a maximum of exactly 1.0
// ====================

package wiener_pkg;

	localparam int PIX_W         = 8;  // one pixel channel
	localparam int BLOCK_SAMPLES = 64; // pixels per block
	localparam int LOG2_SAMPLES  = 6;  // shift for mean and variance, also buffer addr width
	localparam int FRAC_W        = 16; // fraction bits of the gain
	localparam int VAR_W         = 16; // variance and noise variance width

	// per-block statistics, integer mean and variance
	typedef struct packed {
		logic [PIX_W-1:0] mean;
		logic [VAR_W-1:0] variance;
	} block_stats_t;

	// 1.16 unsigned, top bit only set when gain is exactly 1.0
	typedef logic [FRAC_W:0] gain_t;

	typedef struct packed {
		logic [PIX_W-1:0] data;
		logic             last; // final pixel of a block
	} filt_pix_t;

	typedef enum logic [1:0] {
		CALC_IDLE   = 2'd0, // waiting for block stats
		CALC_DIVIDE = 2'd1, // gain divider running
		CALC_STREAM = 2'd2  // replaying the buffered block
	} calc_state_t;

endpackage

//--- src.f
rtl/wiener_pkg.sv
rtl/block_stats.sv
rtl/gain_divider.sv
rtl/wiener_calc.sv
rtl/pixel_out_stage.sv
rtl/wiener_denoise_top.sv
verification/wiener_denoise_props.sv
verification/wiener_denoise_tb.sv

//--- verification/wiener_denoise_props.sv
// ====================
// timing properties on the denoiser outputs, bound to the top level
// checks are disabled while rst_n is low
// ====================
`timescale 1ns/1ps

module wiener_denoise_props (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  out_valid,
	input wiener_pkg::filt_pix_t out_pix,
	input logic                  block_done,
	input logic                  frame_done
);
	import wiener_pkg::*;

	// block end marker only rides on a valid last pixel
	a_block_done_on_last : assert property (@(posedge clk) disable iff (!rst_n)
		block_done |-> (out_valid && out_pix.last))
		else $error("block_done seen without a valid last pixel");

	a_frame_needs_block : assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> block_done)
		else $error("frame_done seen without block_done");

	// pipeline is empty right after reset release
	a_quiet_after_reset : assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
		else $error("out_valid high in the first cycle after reset");

endmodule

bind wiener_denoise_top wiener_denoise_props u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid  (out_valid),
	.out_pix    (out_pix),
	.block_done (block_done),
	.frame_done (frame_done)
);

//--- verification/wiener_denoise_tb.sv
// ====================
// directed tests for the block Wiener denoiser
// one block in flight at a time, next block only after all 64 outputs
// outputs sampled on the falling edge, inputs driven 2 ns after rising
// ====================
`timescale 1ns/1ps

module wiener_denoise_tb;
	import wiener_pkg::*;

	localparam int WAIT_LIMIT = 200; // cycles allowed per output pixel

	logic        clk;
	logic        rst_n;
	logic        pix_valid;
	logic [7:0]  pix_data;
	logic [15:0] noise_variance;
	logic [31:0] blocks_per_frame;
	logic        out_valid;
	filt_pix_t   out_pix;
	logic        block_done;
	logic        frame_done;

	logic [7:0] blk_pix [64]; // block under test
	filt_pix_t  exp_pix [64]; // expected output stream
	integer     seed;
	int         model_mean;
	int         model_var;
	int         err_cnt;
	int         timeout_cnt;
	int         bd_cnt;       // block_done pulses seen
	int         fd_cnt;       // frame_done pulses seen
	int         fd_at;        // block number carrying frame_done

	wiener_denoise_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	always @(negedge clk) begin
		if (rst_n) begin
			if (block_done)
				bd_cnt = bd_cnt + 1;
			if (frame_done) begin
				fd_cnt = fd_cnt + 1;
				fd_at  = bd_cnt; // block_done counted just above
			end
		end
	end

	task automatic apply_reset();
		@(posedge clk);
		#2;
		rst_n     = 1'b0;
		pix_valid = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n  = 1'b1;
		bd_cnt    = 0;
		fd_cnt    = 0;
		fd_at     = 0;
	endtask

	task automatic check_pix(input filt_pix_t got, input filt_pix_t exp, input int idx,
			input string tag);
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s pixel %0d got %0d/%0b expected %0d/%0b", $time, tag,
				idx, got.data, got.last, exp.data, exp.last);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s count %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic fill_random();
		logic [31:0] rnd;
		for (int i = 0; i < 64; i++) begin
			rnd        = $random(seed);
			blk_pix[i] = rnd[7:0];
		end
	endtask

	// integer stats straight from the block definition
	task automatic compute_stats();
		int sum;
		int sumsq;
		sum   = 0;
		sumsq = 0;
		for (int i = 0; i < 64; i++) begin
			sum   += blk_pix[i];
			sumsq += blk_pix[i] * blk_pix[i];
		end
		model_mean = sum >> 6;
		model_var  = (sumsq >> 6) - model_mean * model_mean;
	endtask

	task automatic model_block(input int noise);
		longint gain;
		longint mag;
		compute_stats();
		if (noise >= model_var || model_var == 0)
			gain = 0; // clamped gain
		else
			gain = (longint'(model_var - noise) << 16) / model_var;
		for (int i = 0; i < 64; i++) begin
			if (blk_pix[i] >= model_mean) begin
				mag            = (gain * (blk_pix[i] - model_mean)) >> 16;
				exp_pix[i].data = 8'(model_mean + mag);
			end else begin
				mag            = (gain * (model_mean - blk_pix[i])) >> 16;
				exp_pix[i].data = 8'(model_mean - mag);
			end
			exp_pix[i].last = (i == 63);
		end
	endtask

	task automatic expect_const(input logic [7:0] value);
		for (int i = 0; i < 64; i++) begin
			exp_pix[i].data = value;
			exp_pix[i].last = (i == 63);
		end
	endtask

	task automatic send_block(input logic [15:0] noise);
		for (int i = 0; i < 64; i++) begin
			@(posedge clk);
			#2;
			pix_valid      = 1'b1;
			pix_data       = blk_pix[i];
			noise_variance = noise; // level, held for the whole block
		end
		@(posedge clk);
		#2 pix_valid = 1'b0;
	endtask

	task automatic collect_block(input string tag);
		int  wait_cnt;
		bit  timed_out;
		timed_out = 1'b0;
		for (int i = 0; i < 64 && !timed_out; i++) begin
			wait_cnt = 0;
			@(negedge clk);
			while (!out_valid && wait_cnt < WAIT_LIMIT) begin
				@(negedge clk);
				wait_cnt++;
			end
			if (!out_valid) begin
				timed_out = 1'b1;
				timeout_cnt++;
				$display("Timeout: no output pixel %0d within %0d cycles in %s", i,
					WAIT_LIMIT, tag);
			end else begin
				check_pix(out_pix, exp_pix[i], i, tag);
			end
		end
	endtask

	task automatic test_flat_block();
		for (int i = 0; i < 64; i++)
			blk_pix[i] = 8'd137;
		expect_const(8'd137); // zero variance, gain forced to zero
		send_block(16'd50);
		collect_block("flat block");
	endtask

	task automatic test_unity_gain();
		fill_random();
		for (int i = 0; i < 64; i++) begin
			exp_pix[i].data = blk_pix[i]; // gain of 1.0 passes pixels through
			exp_pix[i].last = (i == 63);
		end
		send_block(16'd0);
		collect_block("unity gain");
	endtask

	task automatic test_noise_floor();
		fill_random();
		compute_stats();
		expect_const(8'(model_mean));
		send_block(16'hffff); // above any block variance
		collect_block("noise floor");
	endtask

	task automatic test_mid_noise();
		fill_random();
		compute_stats();
		model_block(model_var >> 1);
		send_block(16'(model_var >> 1));
		collect_block("mid noise");
	endtask

	task automatic test_frame_pulses();
		apply_reset(); // frame counter back to zero
		blocks_per_frame = 32'd3;
		for (int b = 0; b < 4 && timeout_cnt == 0; b++) begin
			fill_random();
			model_block(500);
			send_block(16'd500);
			collect_block("frame block");
		end
		@(negedge clk);
		check_count(bd_cnt, 4, "block_done");
		check_count(fd_cnt, 1, "frame_done");
		check_count(fd_at, 3, "frame_done block number");
	endtask

	initial begin
		seed             = 32'hed73;
		err_cnt          = 0;
		timeout_cnt      = 0;
		rst_n            = 1'b0;
		pix_valid        = 1'b0;
		pix_data         = '0;
		noise_variance   = '0;
		blocks_per_frame = 32'd3;
		apply_reset();
		test_flat_block();
		if (timeout_cnt == 0)
			test_unity_gain();
		if (timeout_cnt == 0)
			test_noise_floor();
		if (timeout_cnt == 0)
			test_mid_noise();
		if (timeout_cnt == 0)
			test_frame_pulses();
		$display("Done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
